/* hdl/rv_core_pkg.sv */
// RV32I core definitions
`default_nettype none

package rv_core_pkg;

	typedef logic [31:0] xlen_t;
	typedef logic [31:0] addr_t;
	typedef logic [31:0] instr_t;
	typedef logic [4:0] reg_idx_t;

	// Major opcode from instruction bits 6:2
	typedef enum logic [4:0] {
		OP     = 5'b01100,
		OP_IMM = 5'b00100,
		LUI    = 5'b01101,
		AUIPC  = 5'b00101,
		JAL    = 5'b11011,
		JALR   = 5'b11001,
		BRANCH = 5'b11000,
		LOAD   = 5'b00000,
		STORE  = 5'b01000
	} opcode_e;

	typedef enum logic [2:0] {
		FN_ADD_SUB = 3'b000,
		FN_SLL     = 3'b001,
		FN_SLT     = 3'b010,
		FN_SLTU    = 3'b011,
		FN_XOR     = 3'b100,
		FN_SR      = 3'b101,
		FN_OR      = 3'b110,
		FN_AND     = 3'b111
	} funct3_e;

	typedef enum logic [2:0] {
		BR_EQ  = 3'b000,
		BR_NE  = 3'b001,
		BR_LT  = 3'b100,
		BR_GE  = 3'b101,
		BR_LTU = 3'b110,
		BR_GEU = 3'b111
	} branch_e;

	// Memory depths in words
	localparam int IMEM_WORDS_DEFAULT = 64;
	localparam int DMEM_WORDS_DEFAULT = 32;

endpackage

`default_nettype wire

/* hdl/fetch_stage.sv */
// Instruction fetch
`default_nettype none

module fetch_stage #(
	parameter int IMEM_WORDS = rv_core_pkg::IMEM_WORDS_DEFAULT
) (
	input  wire logic                            clk,
	input  wire logic                            reset,
	input  wire logic                            run,
	input  wire rv_core_pkg::addr_t              next_pc,
	input  wire logic                            imem_we,
	input  wire logic [$clog2(IMEM_WORDS)-1:0]   imem_addr,
	input  wire rv_core_pkg::instr_t             imem_wdata,
	output rv_core_pkg::addr_t                   pc,
	output rv_core_pkg::instr_t                  instr,
	output logic                                 valid
);
	import rv_core_pkg::*;

	localparam int IDX_W = $clog2(IMEM_WORDS);

	instr_t imem [IMEM_WORDS];

	// PC holds while the core is stopped
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			pc <= '0;
		else if (run)
			pc <= next_pc;
	end

	// Program load port
	always_ff @(posedge clk)
	begin
		if (imem_we)
			imem[imem_addr] <= imem_wdata;
	end

	// Byte PC to word index, wraps modulo the depth
	assign instr = imem[pc[IDX_W+1:2]];
	assign valid = run;

endmodule

`default_nettype wire

/* hdl/decode_stage.sv */
// Instruction decode
`default_nettype none

module decode_stage (
	input  wire rv_core_pkg::instr_t  instr,
	input  wire logic                 valid,
	output rv_core_pkg::reg_idx_t     rs1,
	output rv_core_pkg::reg_idx_t     rs2,
	output rv_core_pkg::reg_idx_t     rd,
	output rv_core_pkg::opcode_e      opcode,
	output logic [2:0]                funct3,
	output logic                      alt,
	output rv_core_pkg::xlen_t        imm,
	output logic                      reg_we,
	output logic                      mem_we,
	output logic                      is_load
);
	import rv_core_pkg::*;

	logic writes_rd;

	assign rs1 = instr[19:15];
	assign rs2 = instr[24:20];
	assign rd = instr[11:7];
	assign opcode = opcode_e'(instr[6:2]);
	assign funct3 = instr[14:12];
	// Selects sub and sra
	assign alt = instr[30];

	// Immediate by format
	always_comb
	begin
		case (opcode)
			LUI, AUIPC:
				imm = {instr[31:12], 12'b0};
			JAL:
				imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
			BRANCH:
				imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
			STORE:
				imm = {{21{instr[31]}}, instr[30:25], instr[11:7]};
			default:
				imm = {{21{instr[31]}}, instr[30:20]};
		endcase
	end

	always_comb
	begin
		case (opcode)
			OP, OP_IMM, LUI, AUIPC, JAL, JALR, LOAD:
				writes_rd = 1'b1;
			default:
				writes_rd = 1'b0;
		endcase
	end

	// Writes to x0 are dropped here
	assign reg_we = valid && writes_rd && (rd != '0);
	assign mem_we = valid && (opcode == STORE);
	assign is_load = (opcode == LOAD);

endmodule

`default_nettype wire

/* hdl/register_file.sv */
// Integer register file
`default_nettype none

module register_file (
	input  wire logic                   clk,
	input  wire logic                   reset,
	input  wire rv_core_pkg::reg_idx_t  rs1,
	input  wire rv_core_pkg::reg_idx_t  rs2,
	input  wire rv_core_pkg::reg_idx_t  rd,
	input  wire logic                   we,
	input  wire rv_core_pkg::xlen_t     wd,
	output rv_core_pkg::xlen_t          rs1_data,
	output rv_core_pkg::xlen_t          rs2_data
);
	import rv_core_pkg::*;

	xlen_t regs [32];

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end
		else if (we && (rd != '0))
			regs[rd] <= wd;
	end

	// x0 reads as zero
	assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
	assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

/* hdl/execute_stage.sv */
// ALU, branch compare and next PC
`default_nettype none

module execute_stage (
	input  wire rv_core_pkg::addr_t    pc,
	input  wire rv_core_pkg::opcode_e  opcode,
	input  wire logic [2:0]            funct3,
	input  wire logic                  alt,
	input  wire rv_core_pkg::xlen_t    imm,
	input  wire rv_core_pkg::xlen_t    rs1_data,
	input  wire rv_core_pkg::xlen_t    rs2_data,
	output rv_core_pkg::xlen_t         alu_result,
	output rv_core_pkg::addr_t         next_pc
);
	import rv_core_pkg::*;

	xlen_t op_b;
	logic [4:0] shamt;
	xlen_t sra_val;
	logic lt_s;
	xlen_t alu_val;
	logic taken;
	addr_t seq_pc;
	addr_t pc_imm;
	xlen_t rs1_imm;

	// Second operand is rs2 only for register-register ops
	assign op_b = (opcode == OP) ? rs2_data : imm;
	assign shamt = op_b[4:0];
	assign sra_val = $signed(rs1_data) >>> shamt;
	assign lt_s = $signed(rs1_data) < $signed(op_b);
	assign seq_pc = pc + 32'd4;
	assign pc_imm = pc + imm;
	assign rs1_imm = rs1_data + imm;

	always_comb
	begin
		case (funct3_e'(funct3))
			FN_ADD_SUB: alu_val = (opcode == OP && alt) ? rs1_data - op_b : rs1_data + op_b;
			FN_SLL:     alu_val = rs1_data << shamt;
			FN_SLT:     alu_val = {31'b0, lt_s};
			FN_SLTU:    alu_val = {31'b0, rs1_data < op_b};
			FN_XOR:     alu_val = rs1_data ^ op_b;
			FN_SR:      alu_val = alt ? sra_val : rs1_data >> shamt;
			FN_OR:      alu_val = rs1_data | op_b;
			default:    alu_val = rs1_data & op_b;
		endcase
	end

	always_comb
	begin
		case (branch_e'(funct3))
			BR_EQ:   taken = (rs1_data == rs2_data);
			BR_NE:   taken = (rs1_data != rs2_data);
			BR_LT:   taken = $signed(rs1_data) < $signed(rs2_data);
			BR_GE:   taken = $signed(rs1_data) >= $signed(rs2_data);
			BR_LTU:  taken = (rs1_data < rs2_data);
			BR_GEU:  taken = (rs1_data >= rs2_data);
			default: taken = 1'b0;
		endcase
	end

	// Loads and stores take the address path
	always_comb
	begin
		case (opcode)
			OP, OP_IMM: alu_result = alu_val;
			LUI:        alu_result = imm;
			AUIPC:      alu_result = pc_imm;
			JAL, JALR:  alu_result = seq_pc;
			default:    alu_result = rs1_imm;
		endcase
	end

	always_comb
	begin
		case (opcode)
			JAL:     next_pc = pc_imm;
			JALR:    next_pc = {rs1_imm[31:1], 1'b0};
			BRANCH:  next_pc = taken ? pc_imm : seq_pc;
			default: next_pc = seq_pc;
		endcase
	end

endmodule

`default_nettype wire

/* hdl/memory_stage.sv */
// Word data memory and writeback select
`default_nettype none

module memory_stage #(
	parameter int DMEM_WORDS = rv_core_pkg::DMEM_WORDS_DEFAULT
) (
	input  wire logic                clk,
	input  wire rv_core_pkg::xlen_t  addr,
	input  wire rv_core_pkg::xlen_t  wr_data,
	input  wire logic                mem_we,
	input  wire logic                is_load,
	output rv_core_pkg::xlen_t       wb_data
);
	import rv_core_pkg::*;

	localparam int IDX_W = $clog2(DMEM_WORDS);

	xlen_t dmem [DMEM_WORDS];
	logic [IDX_W-1:0] idx;

	// Upper address bits are ignored so accesses wrap
	assign idx = addr[IDX_W+1:2];

	always_ff @(posedge clk)
	begin
		if (mem_we)
			dmem[idx] <= wr_data;
	end

	assign wb_data = is_load ? dmem[idx] : addr;

endmodule

`default_nettype wire

/* hdl/rv_core.sv */
// RV32I single-cycle core
`default_nettype none

module rv_core #(
	parameter int IMEM_WORDS = rv_core_pkg::IMEM_WORDS_DEFAULT,
	parameter int DMEM_WORDS = rv_core_pkg::DMEM_WORDS_DEFAULT
) (
	input  wire logic                           clk,
	input  wire logic                           reset,
	input  wire logic                           run,
	input  wire logic                           imem_we,
	input  wire logic [$clog2(IMEM_WORDS)-1:0]  imem_addr,
	input  wire rv_core_pkg::instr_t            imem_wdata,
	output logic                                wb_valid,
	output rv_core_pkg::reg_idx_t               wb_rd,
	output rv_core_pkg::xlen_t                  wb_data,
	output rv_core_pkg::addr_t                  wb_pc
);
	import rv_core_pkg::*;

	addr_t pc;
	addr_t next_pc;
	instr_t instr;
	logic valid;
	reg_idx_t rs1;
	reg_idx_t rs2;
	reg_idx_t rd;
	opcode_e opcode;
	logic [2:0] funct3;
	logic alt;
	xlen_t imm;
	logic reg_we;
	logic mem_we;
	logic is_load;
	xlen_t rs1_data;
	xlen_t rs2_data;
	xlen_t alu_result;
	xlen_t result;

	fetch_stage #(.IMEM_WORDS(IMEM_WORDS)) fetch_i (
		.clk(clk), .reset(reset), .run(run), .next_pc(next_pc),
		.imem_we(imem_we), .imem_addr(imem_addr), .imem_wdata(imem_wdata),
		.pc(pc), .instr(instr), .valid(valid)
	);

	decode_stage decode_i (
		.instr(instr), .valid(valid), .rs1(rs1), .rs2(rs2), .rd(rd),
		.opcode(opcode), .funct3(funct3), .alt(alt), .imm(imm),
		.reg_we(reg_we), .mem_we(mem_we), .is_load(is_load)
	);

	register_file regs_i (
		.clk(clk), .reset(reset), .rs1(rs1), .rs2(rs2), .rd(rd),
		.we(reg_we), .wd(result), .rs1_data(rs1_data), .rs2_data(rs2_data)
	);

	execute_stage execute_i (
		.pc(pc), .opcode(opcode), .funct3(funct3), .alt(alt), .imm(imm),
		.rs1_data(rs1_data), .rs2_data(rs2_data),
		.alu_result(alu_result), .next_pc(next_pc)
	);

	memory_stage #(.DMEM_WORDS(DMEM_WORDS)) memory_i (
		.clk(clk), .addr(alu_result), .wr_data(rs2_data),
		.mem_we(mem_we), .is_load(is_load), .wb_data(result)
	);

	// Retirement view of the current instruction
	assign wb_valid = reg_we;
	assign wb_rd = rd;
	assign wb_data = result;
	assign wb_pc = pc;

endmodule

`default_nettype wire

/* include/rv_model.svh */
// RV32I encoders and reference model
`ifndef RV_MODEL_SVH
`define RV_MODEL_SVH

localparam int MODEL_DMEM_WORDS = rv_core_pkg::DMEM_WORDS_DEFAULT;

logic [31:0] m_regs [32];
logic [31:0] m_dmem [MODEL_DMEM_WORDS];
logic [31:0] m_pc;

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
	input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd,
	input rv_core_pkg::opcode_e op);
	return {f7, rs2, rs1, f3, rd, op, 2'b11};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
	input logic [2:0] f3, input logic [4:0] rd, input rv_core_pkg::opcode_e op);
	return {imm, rs1, f3, rd, op, 2'b11};
endfunction

function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
	input logic [4:0] rs1);
	return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rv_core_pkg::STORE, 2'b11};
endfunction

function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
	input logic [4:0] rs1, input logic [2:0] f3);
	return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_core_pkg::BRANCH, 2'b11};
endfunction

function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
	input rv_core_pkg::opcode_e op);
	return {imm, rd, op, 2'b11};
endfunction

function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
	return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_core_pkg::JAL, 2'b11};
endfunction

// Data memory persists like the hardware array
function automatic void model_reset();
	for (int i = 0; i < 32; i++)
		m_regs[i] = '0;
	m_pc = '0;
endfunction

function automatic logic [31:0] model_alu(input logic [2:0] f3, input logic sub_sra,
	input logic [31:0] a, input logic [31:0] b);
	logic [31:0] r;
	case (f3)
		3'd0: r = sub_sra ? a - b : a + b;
		3'd1: r = a << b[4:0];
		3'd2: r = {31'b0, $signed(a) < $signed(b)};
		3'd3: r = {31'b0, a < b};
		3'd4: r = a ^ b;
		3'd5:
		begin
			if (sub_sra)
				r = $signed(a) >>> b[4:0];
			else
				r = a >> b[4:0];
		end
		3'd6: r = a | b;
		default: r = a & b;
	endcase
	return r;
endfunction

// One instruction at m_pc, returns 1 when it writes a nonzero rd
function automatic bit model_step(input logic [31:0] ins, output logic [4:0] rd,
	output logic [31:0] data, output logic [31:0] pc);
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] imm_i;
	logic [31:0] imm_s;
	logic [31:0] nxt;
	logic [2:0] f3;
	bit wr;
	bit take;
	a = m_regs[ins[19:15]];
	b = m_regs[ins[24:20]];
	f3 = ins[14:12];
	imm_i = {{20{ins[31]}}, ins[31:20]};
	imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
	rd = ins[11:7];
	pc = m_pc;
	nxt = m_pc + 32'd4;
	data = m_pc + 32'd4;
	wr = 1'b1;
	take = 1'b0;
	case (ins[6:2])
		rv_core_pkg::OP:     data = model_alu(f3, ins[30], a, b);
		rv_core_pkg::OP_IMM: data = model_alu(f3, ins[30] && f3 == 3'd5, a, imm_i);
		rv_core_pkg::LUI:    data = {ins[31:12], 12'b0};
		rv_core_pkg::AUIPC:  data = m_pc + {ins[31:12], 12'b0};
		rv_core_pkg::JAL:
			nxt = m_pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
		rv_core_pkg::JALR:   nxt = (a + imm_i) & ~32'd1;
		rv_core_pkg::LOAD:   data = m_dmem[((a + imm_i) >> 2) % MODEL_DMEM_WORDS];
		rv_core_pkg::STORE:
		begin
			m_dmem[((a + imm_s) >> 2) % MODEL_DMEM_WORDS] = b;
			wr = 1'b0;
		end
		rv_core_pkg::BRANCH:
		begin
			case (f3)
				3'd0: take = (a == b);
				3'd1: take = (a != b);
				3'd4: take = $signed(a) < $signed(b);
				3'd5: take = $signed(a) >= $signed(b);
				3'd6: take = (a < b);
				default: take = (a >= b);
			endcase
			if (take)
				nxt = m_pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
			wr = 1'b0;
		end
		default: wr = 1'b0;
	endcase
	wr = wr && (rd != 5'd0);
	if (wr)
		m_regs[rd] = data;
	m_pc = nxt;
	return wr;
endfunction

`endif

/* test/rv_core_tb.sv */
// RV32I core testbench
`default_nettype none

module rv_core_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import rv_core_pkg::*;

	localparam int IMEM_WORDS = IMEM_WORDS_DEFAULT;
	localparam int DMEM_WORDS = DMEM_WORDS_DEFAULT;
	localparam int STEP_LIMIT = 64;
	localparam int RUN_LIMIT = 500;

	`include "rv_model.svh"

	logic clk;
	logic reset;
	logic run;
	logic imem_we;
	logic [$clog2(IMEM_WORDS)-1:0] imem_addr;
	instr_t imem_wdata;
	logic wb_valid;
	reg_idx_t wb_rd;
	xlen_t wb_data;
	addr_t wb_pc;

	logic [31:0] prog [IMEM_WORDS];
	int prog_len;
	int expected_writes;
	int n_writes;
	int n_checks;
	int n_errors;
	integer seed;

	rv_core #(
		.IMEM_WORDS(IMEM_WORDS),
		.DMEM_WORDS(DMEM_WORDS)
	) rv_core_i (
		.clk(clk), .reset(reset), .run(run),
		.imem_we(imem_we), .imem_addr(imem_addr), .imem_wdata(imem_wdata),
		.wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data), .wb_pc(wb_pc)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [31:0] random_word();
		return $random(seed);
	endfunction

	function automatic void emit(input logic [31:0] ins);
		prog[prog_len] = ins;
		prog_len++;
	endfunction

	// Writes the model sees from address zero up to the halt loop
	function automatic int count_writes(input logic [31:0] halt_pc);
		int n;
		int steps;
		logic [4:0] r;
		logic [31:0] d;
		logic [31:0] p;
		n = 0;
		steps = 0;
		model_reset();
		while (m_pc != halt_pc && steps < 256)
		begin
			if (model_step(prog[m_pc[7:2]], r, d, p))
				n++;
			steps++;
		end
		model_reset();
		return n;
	endfunction

	// Compare each retirement with the next writing instruction of the model
	always @(posedge clk)
	begin : compare
		logic [4:0] erd;
		logic [31:0] edata;
		logic [31:0] epc;
		bit wrote;
		int steps;
		if (!run)
		begin
			assert (!wb_valid)
			else
			begin
				$display("error wb_valid got %h expected %h while run is low at wb_pc %h",
					wb_valid, 1'b0, wb_pc);
				n_errors++;
			end
		end
		else if (wb_valid)
		begin
			wrote = 1'b0;
			steps = 0;
			while (!wrote && steps < STEP_LIMIT)
			begin
				wrote = model_step(prog[m_pc[7:2]], erd, edata, epc);
				steps++;
			end
			if (!wrote)
			begin
				$display("model reached no writing instruction for retirement at %h", wb_pc);
				n_errors++;
			end
			else
			begin
				n_checks += 3;
				assert (wb_pc == epc)
				else
				begin
					$display("error wb_pc got %h expected %h", wb_pc, epc);
					n_errors++;
				end
				assert (wb_rd == erd)
				else
				begin
					$display("error wb_rd got %h expected %h", wb_rd, erd);
					n_errors++;
				end
				assert (wb_data == edata)
				else
				begin
					$display("error wb_data got %h expected %h at pc %h", wb_data, edata, epc);
					n_errors++;
				end
			end
			n_writes++;
		end
	end

	// Load while stopped, reset, then run to the halt loop
	task automatic run_program(input int pause_at);
		logic [31:0] halt_pc;
		int cycles;
		bit paused;
		halt_pc = 32'((prog_len - 1) * 4);
		expected_writes = count_writes(halt_pc);
		for (int i = 0; i < prog_len; i++)
		begin
			@(negedge clk);
			imem_we = 1'b1;
			imem_addr = 6'(i);
			imem_wdata = prog[i];
		end
		@(negedge clk);
		imem_we = 1'b0;
		reset = 1'b1;
		repeat (3) @(negedge clk);
		reset = 1'b0;
		model_reset();
		n_writes = 0;
		repeat (2) @(negedge clk);
		run = 1'b1;
		cycles = 0;
		paused = 1'b0;
		while (n_writes < expected_writes && cycles < RUN_LIMIT)
		begin
			@(negedge clk);
			cycles++;
			// Stall mid program while the PC holds
			if (pause_at > 0 && n_writes == pause_at && !paused)
			begin
				paused = 1'b1;
				run = 1'b0;
				repeat (5) @(negedge clk);
				run = 1'b1;
			end
		end
		if (n_writes < expected_writes)
		begin
			$display("timeout waiting for %0d writes, saw %0d", expected_writes, n_writes);
			n_errors++;
		end
		repeat (4) @(negedge clk);
		run = 1'b0;
		repeat (3) @(negedge clk);
	endtask

	task automatic build_alu();
		logic [31:0] v;
		logic [2:0] f3;
		logic alt;
		logic [11:0] imm;
		prog_len = 0;
		for (int r = 1; r < 11; r++)
		begin
			v = random_word();
			// x1 negative and x2 positive for the fixed signed cases
			if (r == 1)
				v[31] = 1'b1;
			else if (r == 2)
				v[31] = 1'b0;
			if (r < 3)
				v[11] = 1'b0;
			emit(enc_u(v[31:12], 5'(r), LUI));
			emit(enc_i(v[11:0], 5'(r), 3'd0, 5'(r), OP_IMM));
		end
		// Sub, sra, srai, slt and slti on operands of opposite sign
		emit(enc_r(7'h20, 5'd2, 5'd1, 3'd0, 5'd11, OP));
		emit(enc_r(7'h20, 5'd2, 5'd1, 3'd5, 5'd12, OP));
		emit(enc_i({7'h20, v[24:21], 1'b1}, 5'd1, 3'd5, 5'd13, OP_IMM));
		emit(enc_r(7'h00, 5'd2, 5'd1, 3'd2, 5'd14, OP));
		emit(enc_i(12'hfff, 5'd1, 3'd2, 5'd15, OP_IMM));
		for (int k = 0; k < 35; k++)
		begin
			v = random_word();
			f3 = v[2:0];
			alt = v[3] && (f3 == 3'd0 || f3 == 3'd5);
			if (v[19])
				emit(enc_r(alt ? 7'h20 : 7'h00, v[18:14], v[13:9], f3, v[8:4], OP));
			else
			begin
				if (f3 == 3'd1)
					imm = {7'h00, v[24:20]};
				else if (f3 == 3'd5)
					imm = {v[3] ? 7'h20 : 7'h00, v[24:20]};
				else
					imm = v[31:20];
				emit(enc_i(imm, v[13:9], f3, v[8:4], OP_IMM));
			end
		end
		emit(enc_j(21'd0, 5'd0));
	endtask

	task automatic build_upper();
		logic [31:0] v;
		prog_len = 0;
		for (int k = 0; k < 16; k++)
		begin
			v = random_word();
			emit(enc_u(v[31:12], 5'(k + 1), v[0] ? LUI : AUIPC));
		end
		emit(enc_j(21'd0, 5'd0));
	endtask

	// x1 negative and x2 positive, so signed and unsigned orders differ
	task automatic build_branch();
		logic [31:0] v;
		logic [2:0] f3;
		logic [4:0] ra;
		logic [4:0] rb;
		prog_len = 0;
		v = random_word();
		emit(enc_u({1'b1, v[30:12]}, 5'd1, LUI));
		emit(enc_i({1'b0, v[10:0]}, 5'd1, 3'd0, 5'd1, OP_IMM));
		v = random_word();
		emit(enc_u({1'b0, v[30:12]}, 5'd2, LUI));
		emit(enc_i({1'b0, v[10:0]}, 5'd2, 3'd0, 5'd2, OP_IMM));
		for (int b = 0; b < 6; b++)
		begin
			f3 = (b < 2) ? 3'(b) : 3'(b + 2);
			for (int p = 0; p < 3; p++)
			begin
				ra = (p == 1) ? 5'd2 : 5'd1;
				rb = (p == 0) ? 5'd2 : 5'd1;
				emit(enc_b(13'd8, rb, ra, f3));
				emit(enc_i(12'd1, 5'd10, 3'd0, 5'd10, OP_IMM));
				emit(enc_i(12'd1, 5'd11, 3'd0, 5'd11, OP_IMM));
			end
		end
		emit(enc_j(21'd0, 5'd0));
	endtask

	task automatic build_jump();
		prog_len = 0;
		emit(enc_j(21'd8, 5'd5));
		emit(enc_i(12'd1, 5'd6, 3'd0, 5'd6, OP_IMM));
		emit(enc_u(20'd0, 5'd7, AUIPC));
		// Odd offset with bit zero dropped from the target
		emit(enc_i(12'd13, 5'd7, 3'd0, 5'd8, JALR));
		emit(enc_i(12'd2, 5'd6, 3'd0, 5'd6, OP_IMM));
		emit(enc_i(12'd1, 5'd9, 3'd0, 5'd9, OP_IMM));
		emit(enc_j(21'd12, 5'd11));
		emit(enc_i(12'd5, 5'd0, 3'd0, 5'd12, OP_IMM));
		emit(enc_j(21'd8, 5'd13));
		emit(enc_j(21'(-8), 5'd14));
		emit(enc_j(21'd0, 5'd0));
	endtask

	task automatic build_mem();
		logic [31:0] v;
		logic [11:0] offs [8];
		prog_len = 0;
		v = random_word();
		emit(enc_u(v[31:12], 5'd1, LUI));
		for (int k = 0; k < 8; k++)
		begin
			v = random_word();
			offs[k] = {2'b00, v[9:2], 2'b00};
			v = random_word();
			emit(enc_u(v[31:12], 5'd2, LUI));
			emit(enc_i(v[11:0], 5'd2, 3'd0, 5'd2, OP_IMM));
			emit(enc_s(offs[k], 5'd2, 5'd1));
		end
		// Odd loads alias one memory depth higher
		for (int k = 0; k < 8; k++)
			emit(enc_i(offs[k] + ((k % 2 == 1) ? 12'(DMEM_WORDS * 4) : 12'd0),
				5'd1, 3'b010, 5'(10 + k), LOAD));
		emit(enc_j(21'd0, 5'd0));
	endtask

	initial
	begin
		seed = 80458;
		reset = 1'b1;
		run = 1'b0;
		imem_we = 1'b0;
		imem_addr = '0;
		imem_wdata = '0;
		prog_len = 0;
		n_writes = 0;
		n_checks = 0;
		n_errors = 0;
		expected_writes = 0;
		repeat (3) @(negedge clk);
		reset = 1'b0;
		build_alu();
		run_program(25);
		build_upper();
		run_program(0);
		build_branch();
		run_program(0);
		build_jump();
		run_program(3);
		build_mem();
		run_program(0);
		$display("checks %0d errors %0d", n_checks, n_errors);
		if (n_errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire

/* all.f */
+incdir+include
hdl/rv_core_pkg.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/register_file.sv
hdl/execute_stage.sv
hdl/memory_stage.sv
hdl/rv_core.sv
test/rv_core_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f all.f \
	--top-module rv_core_tb -Mdir obj_dir -o rv_core_sim
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

./obj_dir/rv_core_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Checks failed" sim.log; then
	exit 1
fi
if ! grep -q "All checks passed" sim.log; then
	echo "no result line in sim.log"
	exit 1
fi
exit 0
